//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = osCheckerTb
FILELIST = osChecker.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

# a failure line in the log, or no pass line, fails the target
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Verification failed" $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- checker/osRuleMatch.sv
`timescale 1ns/1ps
`include "osChecker_macros.svh"

module osRuleMatch #(
    parameter osCheckerPkg::osRoleT role = osCheckerPkg::roleDownstream
) (
    input  logic                   clk,
    input  logic                   reset,
    osDecodedIf.sink               dec,
    input  osCheckerPkg::substateT substate,
    input  osCheckerPkg::symbolT   linkNumber,
    input  osCheckerPkg::symbolT   laneNumber,
    input  logic                   fieldsChanged,
    input  logic                   counting,
    output logic                   match
);
    import osCheckerPkg::*;

    localparam bit upstream = (role == roleUpstream);

    logic   isTs1;
    logic   isTs2;
    logic   linkPad;
    logic   lanePad;
    logic   linkOwn;
    logic   laneOwn;
    logic   learnedOk;
    logic   learnLink;
    symbolT learnedLink;

    // ####################################################################
    // field predicates.
    // ####################################################################
    assign isTs1     = (dec.startKind == startTs1);
    assign isTs2     = (dec.startKind == startTs2);
    assign linkPad   = (dec.linkField == `SYM_PAD);
    assign lanePad   = (dec.laneField == `SYM_PAD);
    assign linkOwn   = (dec.linkField == linkNumber);
    assign laneOwn   = (dec.laneField == laneNumber);
    assign learnedOk = (dec.linkField == learnedLink);

    // ####################################################################
    // per-substate acceptance.
    // ####################################################################
    always_comb
    begin
        match     = 1'b0;
        learnLink = 1'b0;
        if (dec.valid)
        begin
            case (substate)
                pollingActive:
                begin
                    // TS1 only when not a compliance request or upconfigure is set.
                    match = linkPad && lanePad
                          && (isTs2 || (isTs1 && (!dec.bit43 || dec.upconfigure)));
                end
                pollingConfiguration:
                begin
                    match = isTs2 && linkPad && lanePad;
                end
                configLinkWidthStart:
                begin
                    if (!upstream)
                    begin
                        match = isTs1 && linkOwn && lanePad;
                    end
                    else if (counting)
                    begin
                        match = isTs1 && lanePad && learnedOk;
                    end
                    else
                    begin
                        // upstream takes whatever link the partner proposes.
                        match     = isTs1 && lanePad && !linkPad;
                        learnLink = match;
                    end
                end
                configLinkWidthAccept:
                begin
                    // no rule on the downstream side.
                    match = upstream && isTs1 && linkOwn && !lanePad;
                end
                configLanenumWait, configLanenumAccept:
                begin
                    match = (upstream ? isTs2 : isTs1) && linkOwn && laneOwn;
                end
                configComplete:
                begin
                    match = isTs2 && linkOwn && laneOwn && !(counting && fieldsChanged);
                end
                configIdle:
                begin
                    match = dec.idleSet;
                end
                default:
                begin
                    match = 1'b0;
                end
            endcase
        end
    end

    // link number learned on the first accepted set.
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            learnedLink <= '0;
        end
        else if (learnLink)
        begin
            learnedLink <= dec.linkField;
        end
    end

endmodule

//--- checker/osSequencer.sv
`timescale 1ns/1ps

module osSequencer (
    input  logic                   clk,
    input  logic                   reset,
    osDecodedIf.sink               dec,
    input  osCheckerPkg::substateT substate,
    input  logic                   match,
    output logic                   countUp,
    output logic                   runActive,
    output logic                   counting
);
    import osCheckerPkg::*;

    substateT lastSubstate;
    logic     substateChanged;

    assign substateChanged = (substate != lastSubstate);

    // ####################################################################
    // search / counting phase.
    // ####################################################################
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            counting     <= 1'b0;
            lastSubstate <= detectQuiet;
        end
        else
        begin
            lastSubstate <= substate;
            if (dec.valid)
            begin
                // a match here opens the run for the present substate.
                counting <= match;
            end
            else if (substateChanged)
            begin
                counting <= 1'b0;
            end
        end
    end

    // ####################################################################
    // counter controls.
    // ####################################################################
    // the rules only match on a valid set.
    assign countUp = match;

    // low only when the external run counter has to clear.
    assign runActive = counting || countUp;

endmodule

//--- common/osCheckerPkg.sv
package osCheckerPkg;

    // one symbol of an ordered set.
    typedef logic [7:0] symbolT;

    // ####################################################################
    // training substates, codes as reported by the LTSSM.
    // ####################################################################
    typedef enum logic [3:0] {
        detectQuiet          = 4'd0,
        detectActive         = 4'd1,
        pollingActive        = 4'd2,
        pollingConfiguration = 4'd3,
        configLinkWidthStart  = 4'd4,
        configLinkWidthAccept = 4'd5,
        configLanenumWait     = 4'd6,
        configLanenumAccept   = 4'd7,
        configComplete        = 4'd8,
        configIdle            = 4'd9
    } substateT;

    // port role on the link.
    typedef enum logic {
        roleDownstream = 1'b0,
        roleUpstream   = 1'b1
    } osRoleT;

    // ####################################################################
    // start symbol and identifier classification.
    // ####################################################################
    // a TS1 needs COM or the gen3 TS1 start plus the TS1 identifier.
    // same for TS2 with its own start and identifier.
    typedef enum logic [1:0] {
        startNone = 2'd0,
        startTs1  = 2'd1,
        startTs2  = 2'd2
    } startKindT;

endpackage

//--- common/osChecker_macros.svh
`ifndef OS_CHECKER_MACROS_SVH
`define OS_CHECKER_MACROS_SVH

// width of one ordered set.
`define OS_WIDTH 128

// symbol codes.
`define SYM_PAD      8'hF7
`define SYM_COM      8'hBC
`define SYM_TS1_ID   8'h4A
`define SYM_TS2_ID   8'h45
`define SYM_GEN3_TS1 8'h1E
`define SYM_GEN3_TS2 8'h2D

// field positions inside the set.
`define OS_LINK_LSB  8
`define OS_LANE_LSB  16
`define OS_RATE_LSB  32
`define OS_UPCFG_BIT 42
`define OS_BIT43     43
`define OS_ID_LSB    80

// low part that must be zero for an idle set.
`define OS_IDLE_WIDTH 64

`endif

//--- common/osDecodedIf.sv
`timescale 1ns/1ps

interface osDecodedIf;
    import osCheckerPkg::*;

    logic      valid;
    startKindT startKind;
    symbolT    linkField;
    symbolT    laneField;
    symbolT    rateField;
    logic      upconfigure;
    logic      bit43;
    // low half all zero.
    logic      idleSet;

    modport source (
        output valid,
        output startKind,
        output linkField,
        output laneField,
        output rateField,
        output upconfigure,
        output bit43,
        output idleSet
    );

    modport sink (
        input valid,
        input startKind,
        input linkField,
        input laneField,
        input rateField,
        input upconfigure,
        input bit43,
        input idleSet
    );

endinterface

//--- hdl/osChecker.sv
`timescale 1ns/1ps
`include "osChecker_macros.svh"

module osChecker #(
    parameter osCheckerPkg::osRoleT role = osCheckerPkg::roleDownstream
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  logic [`OS_WIDTH-1:0]   orderedSet,
    input  osCheckerPkg::substateT substate,
    input  osCheckerPkg::symbolT   linkNumber,
    input  osCheckerPkg::symbolT   laneNumber,
    output logic                   countUp,
    output logic                   runActive,
    output osCheckerPkg::symbolT   rateId,
    output osCheckerPkg::symbolT   linkNumberOut,
    output logic                   upconfigureCapability
);

    logic fieldsChanged;
    logic match;
    logic counting;

    // one decoded set shared by all stages.
    osDecodedIf decoded ();

    osDecoder decoder (
        .valid      (valid),
        .orderedSet (orderedSet),
        .dec        (decoded)
    );

    osFieldCapture fieldCapture (
        .clk                   (clk),
        .reset                 (reset),
        .dec                   (decoded),
        .fieldsChanged         (fieldsChanged),
        .rateId                (rateId),
        .linkNumberOut         (linkNumberOut),
        .upconfigureCapability (upconfigureCapability)
    );

    osRuleMatch #(
        .role (role)
    ) ruleMatch (
        .clk           (clk),
        .reset         (reset),
        .dec           (decoded),
        .substate      (substate),
        .linkNumber    (linkNumber),
        .laneNumber    (laneNumber),
        .fieldsChanged (fieldsChanged),
        .counting      (counting),
        .match         (match)
    );

    osSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .dec       (decoded),
        .substate  (substate),
        .match     (match),
        .countUp   (countUp),
        .runActive (runActive),
        .counting  (counting)
    );

endmodule

//--- hdl/osDecoder.sv
`timescale 1ns/1ps
`include "osChecker_macros.svh"

module osDecoder (
    input  logic                 valid,
    input  logic [`OS_WIDTH-1:0] orderedSet,
    osDecodedIf.source           dec
);
    import osCheckerPkg::*;

    symbolT startSym;
    symbolT idSym;
    logic   ts1Start;
    logic   ts2Start;

    assign startSym = orderedSet[7:0];
    assign idSym    = orderedSet[`OS_ID_LSB +: 8];

    // gen3 sets carry their own start symbol per type.
    assign ts1Start = (startSym == `SYM_COM) || (startSym == `SYM_GEN3_TS1);
    assign ts2Start = (startSym == `SYM_COM) || (startSym == `SYM_GEN3_TS2);

    always_comb
    begin
        if (ts1Start && (idSym == `SYM_TS1_ID))
        begin
            dec.startKind = startTs1;
        end
        else if (ts2Start && (idSym == `SYM_TS2_ID))
        begin
            dec.startKind = startTs2;
        end
        else
        begin
            dec.startKind = startNone;
        end
    end

    // ####################################################################
    // field extraction.
    // ####################################################################
    assign dec.valid       = valid;
    assign dec.linkField   = orderedSet[`OS_LINK_LSB +: 8];
    assign dec.laneField   = orderedSet[`OS_LANE_LSB +: 8];
    assign dec.rateField   = orderedSet[`OS_RATE_LSB +: 8];
    assign dec.upconfigure = orderedSet[`OS_UPCFG_BIT];
    assign dec.bit43       = orderedSet[`OS_BIT43];
    assign dec.idleSet     = ~|orderedSet[`OS_IDLE_WIDTH-1:0];

endmodule

//--- hdl/osFieldCapture.sv
`timescale 1ns/1ps

module osFieldCapture (
    input  logic                 clk,
    input  logic                 reset,
    osDecodedIf.sink             dec,
    output logic                 fieldsChanged,
    output osCheckerPkg::symbolT rateId,
    output osCheckerPkg::symbolT linkNumberOut,
    output logic                 upconfigureCapability
);

    // held fields of the last valid set.
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            rateId                <= '0;
            linkNumberOut         <= '0;
            upconfigureCapability <= 1'b0;
        end
        else if (dec.valid)
        begin
            rateId                <= dec.rateField;
            linkNumberOut         <= dec.linkField;
            upconfigureCapability <= dec.upconfigure;
        end
    end

    // compare against what the previous valid set carried.
    // only rate and upconfigure take part, the link field is checked by the rules.
    assign fieldsChanged = dec.valid
                         && ((dec.rateField != rateId)
                          || (dec.upconfigure != upconfigureCapability));

endmodule

//--- osChecker.f
+incdir+common
common/osCheckerPkg.sv
common/osDecodedIf.sv
hdl/osDecoder.sv
hdl/osFieldCapture.sv
checker/osRuleMatch.sv
checker/osSequencer.sv
hdl/osChecker.sv
verification/osChecker_assertions.sv
verification/osCheckerTb.sv

//--- verification/osCheckerTb.sv
`timescale 1ns/1ps
`include "osChecker_macros.svh"

module osCheckerTb;
    import osCheckerPkg::*;

    localparam int resetCycles  = 16;
    // reset plus polling, gen3, role, learning, complete and idle tests.
    localparam int testCycles   = resetCycles + 11 + 8 + 6 + 7 + 8 + 7;
    localparam int timeoutLimit = 2 * testCycles;

    logic                 clk;
    logic                 reset;
    logic                 valid;
    logic [`OS_WIDTH-1:0] orderedSet;
    substateT             substate;
    symbolT               linkNumber;
    symbolT               laneNumber;
    logic   [1:0]         countUp;
    logic   [1:0]         runActive;
    symbolT [1:0]         rateId;
    symbolT [1:0]         linkNumberOut;
    logic   [1:0]         upconfigureCapability;
    logic   [31:0]        lcgState = 32'h7724_68f6;
    int                   cycleCount = 0;
    // fields of the last valid set.
    symbolT               heldRate = '0;
    symbolT               heldLink = '0;
    logic                 heldUpcfg = 1'b0;

    osChecker #(.role(roleDownstream)) dut0 (
        .clk, .reset, .valid, .orderedSet, .substate, .linkNumber, .laneNumber,
        .countUp               (countUp[0]),
        .runActive             (runActive[0]),
        .rateId                (rateId[0]),
        .linkNumberOut         (linkNumberOut[0]),
        .upconfigureCapability (upconfigureCapability[0])
    );

    osChecker #(.role(roleUpstream)) dut1 (
        .clk, .reset, .valid, .orderedSet, .substate, .linkNumber, .laneNumber,
        .countUp               (countUp[1]),
        .runActive             (runActive[1]),
        .rateId                (rateId[1]),
        .linkNumberOut         (linkNumberOut[1]),
        .upconfigureCapability (upconfigureCapability[1])
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    initial
    begin
        wait (cycleCount == timeoutLimit);
        failRun("the tests did not finish before the cycle limit");
    end

    // ####################################################################
    // stimulus helpers.
    // ####################################################################
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [`OS_WIDTH-1:0] randomSet();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    // flags is {bit 43, upconfigure}.
    function automatic logic [`OS_WIDTH-1:0] makeTs(input symbolT start, input symbolT id,
        input symbolT link, input symbolT lane, input symbolT rate, input logic [1:0] flags);
        logic [`OS_WIDTH-1:0] s;
        s                    = randomSet();
        s[7:0]               = start;
        s[`OS_LINK_LSB +: 8] = link;
        s[`OS_LANE_LSB +: 8] = lane;
        s[`OS_RATE_LSB +: 8] = rate;
        s[`OS_UPCFG_BIT]     = flags[0];
        s[`OS_BIT43]         = flags[1];
        s[`OS_ID_LSB +: 8]   = id;
        return s;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            failRun($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic checkSymbol(input string name, input symbolT actual, input symbolT expected);
        if (actual !== expected)
        begin
            failRun($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic expectCounters(input string step, input logic [1:0] cu, input logic [1:0] ra);
        for (int i = 0; i < 2; i++)
        begin
            checkBit($sformatf("dut%0d.countUp at %s", i, step), countUp[i], cu[i]);
            checkBit($sformatf("dut%0d.runActive at %s", i, step), runActive[i], ra[i]);
        end
    endtask

    task automatic checkFields();
        for (int i = 0; i < 2; i++)
        begin
            checkSymbol($sformatf("dut%0d.rateId", i), rateId[i], heldRate);
            checkSymbol($sformatf("dut%0d.linkNumberOut", i), linkNumberOut[i], heldLink);
            checkBit($sformatf("dut%0d.upconfigureCapability", i),
                upconfigureCapability[i], heldUpcfg);
        end
    endtask

    // checks earlier fields before driving one cycle.
    task automatic driveSet(input logic v, input logic [`OS_WIDTH-1:0] s);
        @(negedge clk);
        checkFields();
        valid      = v;
        orderedSet = s;
        if (v)
        begin
            heldRate  = s[`OS_RATE_LSB +: 8];
            heldLink  = s[`OS_LINK_LSB +: 8];
            heldUpcfg = s[`OS_UPCFG_BIT];
        end
        #2;
    endtask

    task automatic enterSubstate(input substateT s);
        @(negedge clk);
        substate = s;
        valid    = 1'b0;
        driveSet(1'b0, randomSet());
        expectCounters(s.name(), 2'b00, 2'b00);
    endtask

    // ####################################################################
    // directed tests.
    // ####################################################################
    task automatic pollingActiveTest();
        enterSubstate(pollingActive);
        repeat (5)
        begin
            driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h02, 2'b00));
            expectCounters("polling TS1", 2'b11, 2'b11);
        end
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h05, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("polling TS1 with link", 2'b00, 2'b11);
        driveSet(1'b0, randomSet());
        expectCounters("idle after break", 2'b00, 2'b00);
        // compliance request counts only with upconfigure.
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h02, 2'b10));
        expectCounters("polling bit 43 alone", 2'b00, 2'b00);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h02, 2'b11));
        expectCounters("polling bit 43 and 42", 2'b11, 2'b11);
    endtask

    task automatic gen3Test();
        enterSubstate(detectQuiet);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("detect TS1", 2'b00, 2'b00);
        enterSubstate(pollingActive);
        driveSet(1'b1, makeTs(`SYM_GEN3_TS1, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h04, 2'b00));
        expectCounters("gen3 TS1 start", 2'b11, 2'b11);
        driveSet(1'b1, makeTs(`SYM_GEN3_TS2, `SYM_TS1_ID, `SYM_PAD, `SYM_PAD, 8'h04, 2'b00));
        expectCounters("gen3 TS2 start with TS1 id", 2'b00, 2'b11);
        driveSet(1'b0, randomSet());
        expectCounters("idle after gen3", 2'b00, 2'b00);
    endtask

    task automatic roleTest();
        enterSubstate(configLanenumWait);
        repeat (2)
        begin
            driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h05, 8'h02, 8'h02, 2'b00));
            expectCounters("lanenum TS1", 2'b01, 2'b01);
        end
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h02, 2'b00));
        expectCounters("lanenum first TS2", 2'b10, 2'b11);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h02, 2'b00));
        expectCounters("lanenum second TS2", 2'b10, 2'b10);
    endtask

    task automatic learningTest();
        enterSubstate(configLinkWidthStart);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h05, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("link 05 proposed", 2'b11, 2'b11);
        // the upstream port now holds link 05.
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h05, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("link 05 after learning", 2'b11, 2'b11);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h06, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("link 06 after learning", 2'b00, 2'b11);
        driveSet(1'b0, randomSet());
        expectCounters("idle in link width", 2'b00, 2'b00);
        // back in search the upstream port takes the new link.
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h06, `SYM_PAD, 8'h02, 2'b00));
        expectCounters("link 06 in search", 2'b10, 2'b10);
    endtask

    task automatic completeTest();
        enterSubstate(configComplete);
        repeat (3)
        begin
            driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h02, 2'b00));
            expectCounters("complete TS2", 2'b11, 2'b11);
        end
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h03, 2'b00));
        expectCounters("rate change mid run", 2'b00, 2'b11);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h03, 2'b00));
        expectCounters("new rate in search", 2'b11, 2'b11);
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS2_ID, 8'h05, 8'h02, 8'h03, 2'b01));
        expectCounters("upconfigure change", 2'b00, 2'b11);
    endtask

    task automatic idleTest();
        enterSubstate(configIdle);
        repeat (2)
        begin
            driveSet(1'b1, {nextRandom(), nextRandom(), 64'h0});
            expectCounters("idle set", 2'b11, 2'b11);
        end
        driveSet(1'b1, makeTs(`SYM_COM, `SYM_TS1_ID, 8'h07, 8'h01, 8'h09, 2'b01));
        expectCounters("TS1 in idle", 2'b00, 2'b11);
        repeat (2)
        begin
            driveSet(1'b0, randomSet());
            expectCounters("no set in idle", 2'b00, 2'b00);
        end
    endtask

    initial
    begin
        reset      = 1'b0;
        valid      = 1'b0;
        orderedSet = '0;
        substate   = detectQuiet;
        linkNumber = 8'h05;
        laneNumber = 8'h02;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b1;
        pollingActiveTest();
        gen3Test();
        roleTest();
        learningTest();
        completeTest();
        idleTest();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- verification/osChecker_assertions.sv
`timescale 1ns/1ps

module osCheckerAssertions (
    input logic clk,
    input logic reset,
    input logic valid,
    input logic countUp,
    input logic runActive
);

    // a set only counts when it is present.
    countNeedsValid: assert property (
        @(posedge clk) disable iff (!reset) !valid |-> !countUp
    ) else $error("countUp high without a valid set");

    // a counted set keeps the run open into the next cycle.
    countImpliesRun: assert property (
        @(posedge clk) disable iff (!reset) countUp |=> runActive
    ) else $error("runActive low in the cycle after a counted set");

    quietInReset: assert property (
        @(posedge clk) !reset |-> (!countUp && !runActive)
    ) else $error("counter controls active during reset");

endmodule

// every sequencer in the design.
bind osSequencer osCheckerAssertions sequencerChecks (
    .clk       (clk),
    .reset     (reset),
    .valid     (dec.valid),
    .countUp   (countUp),
    .runActive (runActive)
);
